// File: files.f
+incdir+hw
hw/fetchPkg.sv
hw/branchTargetBuffer.sv
hw/branchPredictor.sv
hw/returnAddressStack.sv
hw/instCache.sv
hw/fetchStage1.sv
test/fetchChecker.sv
test/fetchStage1Tb.sv

// File: Bender.yml
package:
  name: fetch_stage1

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetchPkg.sv
      - hw/branchTargetBuffer.sv
      - hw/branchPredictor.sv
      - hw/returnAddressStack.sv
      - hw/instCache.sv
      - hw/fetchStage1.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/fetchChecker.sv
      - test/fetchStage1Tb.sv

// File: test/fetchStage1Tb.sv
/*
 * Testbench for the first fetch stage. A table of training updates and
 * redirects is applied in a loop; a memory model answers cache misses and
 * the checker module compares the DUT against its own model.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetchStage1Tb;
	import fetchPkg::*;

	localparam int K_NONE    = 0;                         // just run cycles.
	localparam int K_HOLD    = 1;                         // stall for cycles.
	localparam int K_UPD     = 2;
	localparam int K_EX      = 3;
	localparam int K_EXSTALL = 4;                         // execute redirect under stall.
	localparam int K_PRIO    = 5;                         // mask picks redirect sources.
	localparam int K_FIXCALL = 6;
	localparam int K_FIXRTR  = 7;
	localparam int MemWords  = 4096;
	localparam int MaxWait   = 50;

	typedef struct packed {
		logic [2:0] kind;
		pcT         pc;                                   // update pc, redirect or call pc.
		pcT         tgt;
		ctrlTypeE   ty;
		logic       dir;
		logic [3:0] mask;                                 // recover, exception, execute, decode.
		logic [7:0] cycles;
		pcT         expPc;
		logic       hitChk;
		logic [3:0] expHit;
	} rowT;

	rowT                            rows[$];
	logic                           clk;
	logic                           reset;
	logic                           stall;
	logic                           holdStall;
	logic                           timedOut;
	redirectT                       recover;
	redirectT                       exception;
	redirectT                       redirectEX;
	decodeFixT                      fixID;
	updateT                         update;
	refillT                         refill;
	logic                           fs1Ready;
	logic                           miss;
	pcT                             missAddr;
	pcT                             pc;
	bundleT                         bundle;
	slotPredT [`FETCH_WIDTH-1:0]    slot;
	logic                           chkPc;
	logic                           chkHit;
	pcT                             expPc;
	logic [`FETCH_WIDTH-1:0]        expHit;
	int                             errors;
	instT                           mem [MemWords];

	fetchStage1 i_fetchStage1 (.clk, .reset, .stall_i(stall), .recover_i(recover),
		.exception_i(exception), .fixID_i(fixID), .redirectEX_i(redirectEX),
		.update_i(update), .refill_i(refill), .fs1Ready_o(fs1Ready), .miss_o(miss),
		.missAddr_o(missAddr), .pc_o(pc), .bundle_o(bundle), .slot_o(slot));

	fetchChecker i_fetchChecker (.clk, .reset, .stall_i(stall), .recover_i(recover),
		.exception_i(exception), .redirectEX_i(redirectEX), .fixID_i(fixID),
		.update_i(update), .refill_i(refill), .ready_i(fs1Ready), .miss_i(miss),
		.missAddr_i(missAddr), .pc_i(pc), .bundle_i(bundle), .slot_i(slot),
		.chkPc_i(chkPc), .expPc_i(expPc), .chkHit_i(chkHit), .expHit_i(expHit),
		.errors_o(errors));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;                           // 40 ns period.
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bundleT readLine(input pcT a);
		bundleT b;
		for (int k = 0; k < `FETCH_WIDTH; k++)
			b[k] = mem[((a >> 2) + k) % MemWords];
		return b;
	endfunction

	task automatic addRow(input int kind, input pcT a, input pcT tgt, input ctrlTypeE ty,
		input logic dir, input logic [3:0] mask, input int cycles, input pcT exp,
		input logic hitChk, input logic [3:0] hit);
		rowT r;
		r.kind   = kind;
		r.pc     = a;
		r.tgt    = tgt;
		r.ty     = ty;
		r.dir    = dir;
		r.mask   = mask;
		r.cycles = cycles;
		r.expPc  = exp;
		r.hitChk = hitChk;
		r.expHit = hit;
		rows.push_back(r);
	endtask

	// one clock; refill strobe and stall follow the miss seen after the edge.
	task automatic tick();
		@(posedge clk);
		#2;
		if (refill.wrEnable)
			refill.wrEnable = 1'b0;
		else if (miss)
		begin
			refill.wrEnable = 1'b1;
			refill.wrAddr   = missAddr;
			refill.line     = readLine(missAddr);
		end
		stall = miss || holdStall;
	endtask

	task automatic waitReady();
		int n;
		n = 0;
		while (miss && !timedOut)
		begin
			tick();
			n++;
			if (n > MaxWait)
			begin
				$display("timeout: no cache refill arrived for pc %h", pc);
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic clearInputs();
		recover    = '0;
		exception  = '0;
		redirectEX = '0;
		fixID      = '0;
		update     = '0;
	endtask

	task automatic driveAction(input rowT r);
		case (r.kind)
			K_UPD:
			begin
				update.updateEn = 1'b1;
				update.pc       = r.pc;
				update.target   = r.tgt;
				update.brType   = r.ty;
				update.dir      = r.dir;
			end
			K_EX, K_EXSTALL:
			begin
				redirectEX.flag = 1'b1;
				redirectEX.pc   = r.pc;
			end
			K_PRIO:
			begin
				recover.flag      = r.mask[3];
				recover.pc        = r.pc;
				exception.flag    = r.mask[2];
				exception.pc      = r.pc + 32'h100;
				redirectEX.flag   = r.mask[1];
				redirectEX.pc     = r.pc + 32'h200;
				fixID.flagRecover = r.mask[0];
				fixID.target      = r.pc + 32'h300;
			end
			K_FIXCALL:
			begin
				fixID.flagRecover = 1'b1;
				fixID.flagCall    = 1'b1;
				fixID.callPc      = r.pc;
				fixID.target      = r.tgt;
			end
			default:
			begin
				fixID.flagRecover = 1'b1;
				fixID.flagRtr     = 1'b1;
			end
		endcase
	endtask

	task automatic applyRow(input rowT r);
		waitReady();
		if (r.kind == K_HOLD)
		begin
			holdStall = 1'b1;
			stall     = 1'b1;
			repeat (r.cycles) tick();
			holdStall = 1'b0;
			stall     = miss;
		end
		else
		begin
			if (r.kind != K_NONE)
			begin
				holdStall = (r.kind == K_EXSTALL);
				stall     = holdStall;
				driveAction(r);
				tick();
				clearInputs();
				holdStall = 1'b0;
				stall     = miss;
			end
			repeat (r.cycles)
			begin
				waitReady();
				tick();
			end
		end
		// hold the PC for one edge while the checker takes the table values.
		holdStall = 1'b1;
		stall     = 1'b1;
		chkPc     = 1'b1;
		expPc     = r.expPc;
		chkHit    = r.hitChk;
		expHit    = r.expHit;
		tick();
		chkPc     = 1'b0;
		chkHit    = 1'b0;
		holdStall = 1'b0;
		stall     = miss;
	endtask

	task automatic buildTable();
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 0, 32'h0, 0, 0);            // after reset.
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 3, 32'h30, 0, 0);
		addRow(K_HOLD, 0, 0, CT_JUMP, 0, 0, 4, 32'h30, 0, 0);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'h40, 0, 0);
		addRow(K_UPD, 32'h208, 32'h400, CT_JUMP, 1, 0, 0, 32'h50, 0, 0);
		addRow(K_EX, 32'h200, 0, CT_JUMP, 0, 0, 0, 32'h200, 1, 4'b0100);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'h400, 0, 0);          // jump taken.
		addRow(K_UPD, 32'h608, 32'h800, CT_BRANCH, 0, 0, 0, 32'h410, 0, 0);
		addRow(K_UPD, 32'h608, 32'h800, CT_BRANCH, 1, 0, 0, 32'h420, 0, 0);
		addRow(K_EX, 32'h600, 0, CT_JUMP, 0, 0, 0, 32'h600, 1, 4'b0100);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'h610, 0, 0);          // still not taken.
		addRow(K_UPD, 32'h608, 32'h800, CT_BRANCH, 1, 0, 0, 32'h620, 0, 0);
		addRow(K_EX, 32'h600, 0, CT_JUMP, 0, 0, 0, 32'h600, 1, 4'b0100);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'h800, 0, 0);
		addRow(K_UPD, 32'h608, 32'h900, CT_BRANCH, 0, 0, 0, 32'h810, 0, 0);
		addRow(K_EX, 32'h600, 0, CT_JUMP, 0, 0, 0, 32'h600, 1, 4'b0100);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'h610, 0, 0);
		addRow(K_UPD, 32'hA04, 32'hC00, CT_CALL, 1, 0, 0, 32'h620, 0, 0);
		addRow(K_UPD, 32'hC08, 32'hE00, CT_CALL, 1, 0, 0, 32'h630, 0, 0);
		addRow(K_UPD, 32'hE0C, 32'h0, CT_RETURN, 1, 0, 0, 32'h640, 0, 0);
		addRow(K_UPD, 32'hC14, 32'h0, CT_RETURN, 1, 0, 0, 32'h650, 0, 0);
		addRow(K_EX, 32'hA00, 0, CT_JUMP, 0, 0, 0, 32'hA00, 1, 4'b0010);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'hC00, 0, 0);          // outer call.
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'hE00, 0, 0);          // inner call.
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'hC0C, 0, 0);
		addRow(K_NONE, 0, 0, CT_JUMP, 0, 0, 1, 32'hA08, 0, 0);
		addRow(K_PRIO, 32'h1000, 0, CT_JUMP, 0, 4'b1111, 0, 32'h1000, 0, 0);
		addRow(K_PRIO, 32'h1000, 0, CT_JUMP, 0, 4'b0111, 0, 32'h1100, 0, 0);
		addRow(K_PRIO, 32'h1000, 0, CT_JUMP, 0, 4'b0011, 0, 32'h1200, 0, 0);
		addRow(K_PRIO, 32'h1000, 0, CT_JUMP, 0, 4'b0001, 0, 32'h1300, 0, 0);
		addRow(K_EXSTALL, 32'h1400, 0, CT_JUMP, 0, 0, 0, 32'h1400, 0, 0);
		addRow(K_FIXCALL, 32'h1508, 32'h1600, CT_JUMP, 0, 0, 0, 32'h1600, 0, 0);
		addRow(K_FIXRTR, 0, 0, CT_JUMP, 0, 0, 0, 32'h1508, 0, 0);
	endtask

	initial
	begin
		logic [31:0] seed;
		reset     = 1'b1;
		stall     = 1'b0;
		holdStall = 1'b0;
		timedOut  = 1'b0;
		chkPc     = 1'b0;
		chkHit    = 1'b0;
		expPc     = '0;
		expHit    = '0;
		refill    = '0;
		clearInputs();
		seed = 32'he0e6;
		for (int i = 0; i < MemWords; i++)
		begin
			seed   = lcgNext(seed ^ i);                   // mixes in the word address.
			mem[i] = seed;
		end
		buildTable();
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		stall = miss;                                     // pc 0 misses after reset.
		foreach (rows[r])
		begin
			if (!timedOut)
				applyRow(rows[r]);
		end
		$display("checks done: %0d errors, %0d timeouts", errors, timedOut);
		if ((errors == 0) && !timedOut)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/fetchChecker.sv
/*
 * Reference checker for the first fetch stage. It mirrors the cache, target
 * buffer, counters and return stack from the DUT's inputs and compares every
 * output once per cycle. The testbench also strobes in table expectations.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetchChecker (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 stall_i,
	input  fetchPkg::redirectT                   recover_i,
	input  fetchPkg::redirectT                   exception_i,
	input  fetchPkg::redirectT                   redirectEX_i,
	input  fetchPkg::decodeFixT                  fixID_i,
	input  fetchPkg::updateT                     update_i,
	input  fetchPkg::refillT                     refill_i,
	input  logic                                 ready_i,
	input  logic                                 miss_i,
	input  fetchPkg::pcT                         missAddr_i,
	input  fetchPkg::pcT                         pc_i,
	input  fetchPkg::bundleT                     bundle_i,
	input  fetchPkg::slotPredT [`FETCH_WIDTH-1:0] slot_i,
	input  logic                                 chkPc_i,
	input  fetchPkg::pcT                         expPc_i,
	input  logic                                 chkHit_i,
	input  logic [`FETCH_WIDTH-1:0]              expHit_i,
	output int                                   errors_o
);
	import fetchPkg::*;

	localparam int BtbSlots = `BTB_DEPTH * `FETCH_WIDTH;    // one entry per word.

	pcT         mPc;                                      // model fetch PC.
	logic       btbV [BtbSlots];
	pcT         btbPc [BtbSlots];                         // full pc kept as the tag.
	ctrlTypeE   btbType [BtbSlots];
	pcT         btbTgt [BtbSlots];
	logic [1:0] ctrM [`BP_DEPTH];
	logic       cV [`CACHE_LINES];
	pcT         cAddr [`CACHE_LINES];                     // line base address.
	bundleT     cLine [`CACHE_LINES];
	pcT         rStack [`RAS_DEPTH];
	int         rTos;

	function automatic int btbIdx(input pcT a);
		return (a >> 2) % BtbSlots;
	endfunction

	function automatic int ctrIdx(input pcT a);
		return (a >> 2) % `BP_DEPTH;
	endfunction

	function automatic int lineIdx(input pcT a);
		return (a >> 4) % `CACHE_LINES;
	endfunction

	task automatic checkVal(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
			errors_o++;
		end
	endtask

	always @(posedge clk)
	begin
		pcT                      spc;
		pcT                      nPc;
		pcT                      pushA;
		pcT                      tgt;
		logic                    hit;
		logic                    pred;
		logic                    found;
		logic                    push;
		logic                    pop;
		logic                    eMiss;
		logic [`FETCH_WIDTH-1:0] hits;
		int                      li;
		if (reset)
		begin
			mPc      = '0;
			rTos     = 0;
			errors_o = 0;
			for (int i = 0; i < BtbSlots; i++)
				btbV[i] = 1'b0;
			for (int i = 0; i < `BP_DEPTH; i++)
				ctrM[i] = 2'b01;                          // weakly not taken.
			for (int i = 0; i < `CACHE_LINES; i++)
				cV[i] = 1'b0;
			for (int i = 0; i < `RAS_DEPTH; i++)
				rStack[i] = '0;
		end
		else
		begin
			checkVal("pc_o", pc_i, mPc);
			li    = lineIdx(mPc);
			eMiss = !cV[li] || (cAddr[li] != {mPc[`SIZE_PC-1:4], 4'h0});
			checkVal("miss_o", miss_i, eMiss);
			checkVal("fs1Ready_o", ready_i, !eMiss);
			checkVal("missAddr_o", missAddr_i, {mPc[`SIZE_PC-1:4], 4'h0});
			if (!eMiss)
				checkVal("bundle_o", bundle_i, cLine[li]);

			// default is the next sequential bundle.
			nPc   = mPc + 16;
			found = 1'b0;
			push  = 1'b0;
			pop   = 1'b0;
			pushA = '0;
			for (int k = 0; k < `FETCH_WIDTH; k++)
			begin
				spc     = mPc + 4 * k;
				hit     = btbV[btbIdx(spc)] && (btbPc[btbIdx(spc)] == spc);
				pred    = ctrM[ctrIdx(spc)][1];
				hits[k] = slot_i[k].btbHit;               // DUT hits for the table check.
				tgt     = (btbType[btbIdx(spc)] == CT_RETURN) ? rStack[rTos] : btbTgt[btbIdx(spc)];
				checkVal($sformatf("slot_o[%0d].btbHit", k), slot_i[k].btbHit, hit);
				checkVal($sformatf("slot_o[%0d].prediction", k), slot_i[k].prediction, pred);
				if (hit)
				begin
					checkVal($sformatf("slot_o[%0d].ctrlType", k), slot_i[k].ctrlType,
						btbType[btbIdx(spc)]);
					checkVal($sformatf("slot_o[%0d].target", k), slot_i[k].target, tgt);
				end
				if (hit && !found && ((btbType[btbIdx(spc)] != CT_BRANCH) || pred))
				begin
					found = 1'b1;
					nPc   = tgt;
					pop   = (btbType[btbIdx(spc)] == CT_RETURN);
					push  = (btbType[btbIdx(spc)] == CT_CALL);
					pushA = spc + 4;                      // return lands after the call.
				end
			end
			if (chkPc_i)
				checkVal("pc_o (table)", pc_i, expPc_i);
			if (chkHit_i)
				checkVal("slot_o.btbHit (table)", hits, expHit_i);

			// later stage redirects override the prediction.
			if (redirectEX_i.flag)
			begin
				nPc  = redirectEX_i.pc;
				push = 1'b0;
				pop  = 1'b0;
			end
			else if (fixID_i.flagRecover)
			begin
				pop   = fixID_i.flagRtr;
				push  = fixID_i.flagCall && !fixID_i.flagRtr;
				pushA = fixID_i.callPc;
				nPc   = fixID_i.flagRtr ? rStack[rTos] : fixID_i.target;
			end
			if (stall_i || recover_i.flag || exception_i.flag)
			begin
				push = 1'b0;
				pop  = 1'b0;
			end
			if (push)
			begin
				rTos         = (rTos + 1) % `RAS_DEPTH;
				rStack[rTos] = pushA;
			end
			else if (pop)
				rTos = (rTos + `RAS_DEPTH - 1) % `RAS_DEPTH;

			if (recover_i.flag)
				mPc = recover_i.pc;
			else if (exception_i.flag)
				mPc = exception_i.pc;
			else if (redirectEX_i.flag || !stall_i)
				mPc = nPc;

			// training lands at this edge.
			if (update_i.updateEn && (update_i.brType == CT_BRANCH))
			begin
				li = ctrIdx(update_i.pc);
				if (update_i.dir && (ctrM[li] != 2'b11))
					ctrM[li] = ctrM[li] + 1;
				else if (!update_i.dir && (ctrM[li] != 2'b00))
					ctrM[li] = ctrM[li] - 1;
			end
			if (update_i.updateEn && !((update_i.brType == CT_BRANCH) && !update_i.dir))
			begin
				li          = btbIdx(update_i.pc);
				btbV[li]    = 1'b1;
				btbPc[li]   = update_i.pc;
				btbType[li] = update_i.brType;
				btbTgt[li]  = update_i.target;
			end
			if (refill_i.wrEnable)
			begin
				li        = lineIdx(refill_i.wrAddr);
				cV[li]    = 1'b1;
				cAddr[li] = {refill_i.wrAddr[`SIZE_PC-1:4], 4'h0};
				cLine[li] = refill_i.line;
			end
		end
	end

endmodule

// File: hw/fetchStage1.sv
/*
 * First fetch stage: PC register, cache and predictor lookup, and the
 * next-PC priority encoder. Redirect inputs reach pc_o one cycle later; the
 * environment stalls the stage while fs1Ready_o is low.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetchStage1 (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 stall_i,
	input  fetchPkg::redirectT                   recover_i,
	input  fetchPkg::redirectT                   exception_i,
	input  fetchPkg::decodeFixT                  fixID_i,
	input  fetchPkg::redirectT                   redirectEX_i,
	input  fetchPkg::updateT                     update_i,
	input  fetchPkg::refillT                     refill_i,
	output logic                                 fs1Ready_o,
	output logic                                 miss_o,
	output fetchPkg::pcT                         missAddr_o,
	output fetchPkg::pcT                         pc_o,
	output fetchPkg::bundleT                     bundle_o,
	output fetchPkg::slotPredT [`FETCH_WIDTH-1:0] slot_o
);
	import fetchPkg::*;

	pcT                          pcReg;                  // fetch PC.
	pcT                          nextPc;
	pcT                          predPc;                 // PC from the bundle's prediction.
	logic                        btbWriteEn;
	logic                        bpUpdateEn;
	logic [`FETCH_WIDTH-1:0]     btbHit;
	ctrlTypeE [`FETCH_WIDTH-1:0] btbType;
	pcT [`FETCH_WIDTH-1:0]       btbTarget;
	pcT [`FETCH_WIDTH-1:0]       slotTarget;             // stack top replaces return targets.
	logic [`FETCH_WIDTH-1:0]     prediction;
	logic [`FETCH_WIDTH-1:0]     taken;
	logic                        predPush;
	logic                        predPop;
	pcT                          predPushAddr;
	logic                        rasPush;
	logic                        rasPop;
	logic                        rasPushEn;
	logic                        rasPopEn;
	pcT                          rasPushAddr;
	pcT                          rasTop;
	logic                        miss;

	// counters learn only conditional branches; not-taken branches skip the buffer.
	assign bpUpdateEn = update_i.updateEn && (update_i.brType == CT_BRANCH);
	assign btbWriteEn = update_i.updateEn && !((update_i.brType == CT_BRANCH) && !update_i.dir);

	branchTargetBuffer btb (.clk, .reset, .pc_i(pcReg), .update_i, .writeEn_i(btbWriteEn),
		.hit_o(btbHit), .ctrlType_o(btbType), .target_o(btbTarget));

	branchPredictor bp (.clk, .reset, .pc_i(pcReg), .updatePc_i(update_i.pc),
		.updateDir_i(update_i.dir), .updateEn_i(bpUpdateEn), .prediction_o(prediction));

	returnAddressStack ras (.clk, .reset, .push_i(rasPushEn), .pushAddr_i(rasPushAddr),
		.pop_i(rasPopEn), .top_o(rasTop));

	instCache icache (.clk, .reset, .pc_i(pcReg), .refill_i, .bundle_o, .miss_o(miss),
		.missAddr_o);

	always_comb
	begin
		for (int k = 0; k < `FETCH_WIDTH; k++)
		begin
			taken[k]      = btbHit[k] && ((btbType[k] != CT_BRANCH) || prediction[k]);
			slotTarget[k] = (btbType[k] == CT_RETURN) ? rasTop : btbTarget[k];
			slot_o[k]     = '{btbHit: btbHit[k], prediction: prediction[k],
				ctrlType: btbType[k], target: slotTarget[k]};
		end
	end

	// first taken slot wins, else fall through to the next bundle.
	always_comb
	begin
		logic found;
		found        = 1'b0;
		predPc       = pcReg + pcT'(16);
		predPush     = 1'b0;
		predPop      = 1'b0;
		predPushAddr = pcReg;
		for (int k = 0; k < `FETCH_WIDTH; k++)
		begin
			if (taken[k] && !found)
			begin
				found        = 1'b1;
				predPc       = slotTarget[k];
				predPop      = (btbType[k] == CT_RETURN);
				predPush     = (btbType[k] == CT_CALL);
				predPushAddr = pcReg + (pcT'(k + 1) << 2); // address after the call.
			end
		end
	end

	// only the source that supplies the next PC may touch the stack.
	always_comb
	begin
		nextPc      = predPc;
		rasPush     = predPush;
		rasPop      = predPop;
		rasPushAddr = predPushAddr;
		if (redirectEX_i.flag)
		begin
			nextPc  = redirectEX_i.pc;
			rasPush = 1'b0;
			rasPop  = 1'b0;
		end
		else if (fixID_i.flagRecover)
		begin
			nextPc      = fixID_i.flagRtr ? rasTop : fixID_i.target;
			rasPop      = fixID_i.flagRtr;
			rasPush     = fixID_i.flagCall && !fixID_i.flagRtr;
			rasPushAddr = fixID_i.callPc;
		end
	end

	assign rasPushEn = rasPush && !stall_i && !recover_i.flag && !exception_i.flag;
	assign rasPopEn  = rasPop && !stall_i && !recover_i.flag && !exception_i.flag;

	always_ff @(posedge clk)
	begin
		if (reset)
			pcReg <= '0;
		else if (recover_i.flag)
			pcReg <= recover_i.pc;
		else if (exception_i.flag)
			pcReg <= exception_i.pc;
		else if (redirectEX_i.flag || !stall_i)            // execute redirect ignores stall.
			pcReg <= nextPc;
	end

	assign pc_o       = pcReg;
	assign miss_o     = miss;
	assign fs1Ready_o = !miss;

	assert property (@(posedge clk) disable iff (reset) !(rasPushEn && rasPopEn));
	// all redirect sources and trained targets deliver word addresses.
	assert property (@(posedge clk) disable iff (reset) pcReg[1:0] == 2'b00);

endmodule

// File: hw/instCache.sv
/*
 * Direct-mapped instruction cache holding one fetch bundle per line.
 * Lookup is combinational from the fetch PC and reports a miss with the
 * line address; a refill strobe writes the line and its tag at the edge.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module instCache (
	input  logic             clk,
	input  logic             reset,
	input  fetchPkg::pcT     pc_i,
	input  fetchPkg::refillT refill_i,
	output fetchPkg::bundleT bundle_o,
	output logic             miss_o,
	output fetchPkg::pcT     missAddr_o
);
	import fetchPkg::*;

	localparam int OffW = $clog2(`FETCH_WIDTH * `INST_WIDTH / 8); // bytes per line.
	localparam int IdxW = $clog2(`CACHE_LINES);
	localparam int TagW = `SIZE_PC - IdxW - OffW;

	bundleT                   lineMem [`CACHE_LINES];
	logic [TagW-1:0]          tagMem [`CACHE_LINES];
	logic [`CACHE_LINES-1:0]  valid;                     // all lines invalid after reset.
	logic [IdxW-1:0]          rdIdx;
	logic [IdxW-1:0]          wrIdx;

	assign rdIdx = pc_i[OffW +: IdxW];
	assign wrIdx = refill_i.wrAddr[OffW +: IdxW];

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= '0;
		else if (refill_i.wrEnable)
			valid[wrIdx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (refill_i.wrEnable)
		begin
			lineMem[wrIdx] <= refill_i.line;
			tagMem[wrIdx]  <= refill_i.wrAddr[`SIZE_PC-1 -: TagW];
		end
	end

	assign bundle_o   = lineMem[rdIdx];
	assign miss_o     = !valid[rdIdx] || (tagMem[rdIdx] != pc_i[`SIZE_PC-1 -: TagW]);
	assign missAddr_o = {pc_i[`SIZE_PC-1:OffW], {OffW{1'b0}}}; // line aligned.

endmodule

// File: hw/returnAddressStack.sv
/*
 * Circular return address stack. A push writes above the top pointer and a
 * pop moves the pointer down; the top entry is read combinationally.
 * When full, the pointer wraps and the oldest entry is overwritten.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module returnAddressStack (
	input  logic         clk,
	input  logic         reset,
	input  logic         push_i,
	input  fetchPkg::pcT pushAddr_i,
	input  logic         pop_i,
	output fetchPkg::pcT top_o
);
	import fetchPkg::*;

	localparam int PtrW = $clog2(`RAS_DEPTH);

	pcT              stack [`RAS_DEPTH];
	logic [PtrW-1:0] tos;                                // points at the current top.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tos <= '0;
			for (int i = 0; i < `RAS_DEPTH; i++)
				stack[i] <= '0;                          // empty stack reads as zero.
		end
		else if (push_i)
		begin
			tos                <= tos + 1'b1;            // wraps on overflow.
			stack[tos + 1'b1]  <= pushAddr_i;
		end
		else if (pop_i)
			tos <= tos - 1'b1;
	end

	assign top_o = stack[tos];

	// the stage selects at most one stack effect per cycle.
	assert property (@(posedge clk) disable iff (reset) !(push_i && pop_i));

endmodule

// File: hw/branchPredictor.sv
/*
 * Direction predictor of two-bit saturating counters indexed by word address.
 * Each slot reads the counter of its own address; conditional branch
 * outcomes train one counter per cycle.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module branchPredictor (
	input  logic                    clk,
	input  logic                    reset,
	input  fetchPkg::pcT            pc_i,
	input  fetchPkg::pcT            updatePc_i,
	input  logic                    updateDir_i,
	input  logic                    updateEn_i,
	output logic [`FETCH_WIDTH-1:0] prediction_o
);
	import fetchPkg::*;

	localparam int IdxW = $clog2(`BP_DEPTH);

	logic [1:0]      ctr [`BP_DEPTH];                    // msb is the taken prediction.
	logic [IdxW-1:0] updIdx;

	assign updIdx = updatePc_i[2 +: IdxW];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `BP_DEPTH; i++)
				ctr[i] <= 2'b01;                         // weakly not taken.
		end
		else if (updateEn_i)
		begin
			if (updateDir_i && (ctr[updIdx] != 2'b11))
				ctr[updIdx] <= ctr[updIdx] + 2'b01;      // count up on taken.
			else if (!updateDir_i && (ctr[updIdx] != 2'b00))
				ctr[updIdx] <= ctr[updIdx] - 2'b01;      // count down on not taken.
		end
	end

	always_comb
	begin
		pcT slotPc;
		for (int k = 0; k < `FETCH_WIDTH; k++)
		begin
			slotPc          = pc_i + (pcT'(k) << 2);
			prediction_o[k] = ctr[slotPc[2 +: IdxW]][1];
		end
	end

endmodule

// File: hw/branchTargetBuffer.sv
/*
 * Direct-mapped branch target buffer with one entry per slot word of a set.
 * All four slots are looked up combinationally from the fetch PC; the
 * training port writes one entry at the clock edge.
 */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module branchTargetBuffer (
	input  logic                                 clk,
	input  logic                                 reset,
	input  fetchPkg::pcT                         pc_i,
	input  fetchPkg::updateT                     update_i,
	input  logic                                 writeEn_i,
	output logic [`FETCH_WIDTH-1:0]              hit_o,
	output fetchPkg::ctrlTypeE [`FETCH_WIDTH-1:0] ctrlType_o,
	output fetchPkg::pcT [`FETCH_WIDTH-1:0]      target_o
);
	import fetchPkg::*;

	localparam int IdxW    = $clog2(`BTB_DEPTH) + $clog2(`FETCH_WIDTH); // set plus slot word.
	localparam int TagW    = `SIZE_PC - IdxW - 2;
	localparam int Entries = `BTB_DEPTH * `FETCH_WIDTH;

	logic [Entries-1:0] valid;                           // cleared at reset.
	logic [TagW-1:0]    tagMem [Entries];
	ctrlTypeE           typeMem [Entries];
	pcT                 targetMem [Entries];
	logic [IdxW-1:0]    wrIdx;

	assign wrIdx = update_i.pc[2 +: IdxW];               // word address picks set and slot.

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= '0;
		else if (writeEn_i)
			valid[wrIdx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (writeEn_i)
		begin
			tagMem[wrIdx]    <= update_i.pc[`SIZE_PC-1 -: TagW];
			typeMem[wrIdx]   <= update_i.brType;
			targetMem[wrIdx] <= update_i.target;
		end
	end

	// slot k looks up the word at pc_i plus 4k.
	always_comb
	begin
		pcT              slotPc;
		logic [IdxW-1:0] idx;
		for (int k = 0; k < `FETCH_WIDTH; k++)
		begin
			slotPc        = pc_i + (pcT'(k) << 2);
			idx           = slotPc[2 +: IdxW];
			hit_o[k]      = valid[idx] && (tagMem[idx] == slotPc[`SIZE_PC-1 -: TagW]);
			ctrlType_o[k] = typeMem[idx];
			target_o[k]   = targetMem[idx];
		end
	end

	// the stage derives the write enable from the update record.
	assert property (@(posedge clk) disable iff (reset) writeEn_i |-> update_i.updateEn);

endmodule

// File: hw/fetchPkg.sv
/*
 * Shared types of the fetch stage: PC and instruction vectors, the control
 * type encoding and the records passed between the stage and its environment.
 */
`include "fetch_defs.svh"

package fetchPkg;

	typedef logic [`SIZE_PC-1:0] pcT;                    // a fetch or target address.
	typedef logic [`INST_WIDTH-1:0] instT;               // one instruction word.
	typedef instT [`FETCH_WIDTH-1:0] bundleT;            // slot 0 in the low word.

	// encoding follows the control type field of the update queue.
	typedef enum logic [1:0] {
		CT_RETURN = 2'd0,
		CT_CALL   = 2'd1,
		CT_JUMP   = 2'd2,
		CT_BRANCH = 2'd3
	} ctrlTypeE;

	typedef struct packed {
		logic     btbHit;                                // target buffer hit for this slot.
		logic     prediction;                            // counter msb.
		ctrlTypeE ctrlType;                              // stored control type.
		pcT       target;                                // stack top for a return.
	} slotPredT;

	typedef struct packed {
		logic     updateEn;                              // record is valid.
		pcT       pc;                                    // pc of the control instruction.
		pcT       target;                                // resolved target.
		ctrlTypeE brType;                                // resolved control type.
		logic     dir;                                   // resolved direction, 1 is taken.
	} updateT;

	typedef struct packed {
		logic flag;                                      // redirect is valid.
		pcT   pc;                                        // redirect target.
	} redirectT;

	typedef struct packed {
		logic flagRecover;                               // decode repair is valid.
		logic flagCall;                                  // missed call, push callPc.
		pcT   callPc;                                    // return address of that call.
		logic flagRtr;                                   // missed return, target is stack top.
		pcT   target;                                    // direct target from decode.
	} decodeFixT;

	typedef struct packed {
		logic   wrEnable;                                // refill strobe.
		pcT     wrAddr;                                  // address inside the line.
		bundleT line;                                    // line data.
	} refillT;

endpackage

// File: hw/fetch_defs.svh
/*
 * Sizing macros for the first fetch stage and its prediction structures.
 * Include wherever a width or a table depth is needed.
 */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

`define SIZE_PC      32   // program counter width.
`define FETCH_WIDTH  4    // instruction slots per bundle.
`define INST_WIDTH   32   // one instruction word.

`define BTB_DEPTH    64   // target buffer sets, four slot words each.
`define BP_DEPTH     256  // two-bit counter entries.
`define RAS_DEPTH    8    // return address stack entries, power of two.
`define CACHE_LINES  32   // direct-mapped cache lines, one bundle each.

`endif
